//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make help   list these targets"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_rhythmGame -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_rhythmGame); echo "$$out"; echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf obj_dir

//--- build.f
+incdir+.
rhythmPkg.sv
noteSequencer.sv
laneSlots.sv
hitJudge.sv
scoreDisplay.sv
rhythmGame.sv
tb_rhythmChecks.sv
tb_rhythmGame.sv

//--- hitJudge.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module hitJudge
(
	input  logic DIV_CLK,
	input  logic reset,
	input  logic gameStep,
	input  logic playing,
	input  logic clearGame,
	input  rhythmPkg::laneMask_t laneButton,
	input  rhythmPkg::laneMask_t inWindow,
	output rhythmPkg::score_t score
);
	import rhythmPkg::*;

	localparam int COOL_BITS = $clog2(`COOLDOWN_STEPS + 1);

	laneMask_t buttonSample;
	laneMask_t armed;
	laneMask_t scoring;
	logic [COOL_BITS-1:0] cooldown [`LANE_COUNT];

	// buttons are sampled every cycle, judged on the step
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			buttonSample <= '0;
		else
			buttonSample <= laneButton;
	end

	assign scoring = playing ? (buttonSample & armed & inWindow) : '0;

	////////////////////////////////////////
	// per-lane arm and cooldown
	////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			armed <= '1;
			for (int l = 0; l < `LANE_COUNT; l++)
				cooldown[l] <= '0;
		end
		else if (clearGame)
		begin
			armed <= '1;
			for (int l = 0; l < `LANE_COUNT; l++)
				cooldown[l] <= '0;
		end
		else if (gameStep)
		begin
			for (int l = 0; l < `LANE_COUNT; l++)
			begin
				if (buttonSample[l])
				begin
					if (scoring[l])
						armed[l] <= 1'b0;
				end
				else if (cooldown[l] == COOL_BITS'(`COOLDOWN_STEPS))
				begin
					armed[l] <= 1'b1;
					cooldown[l] <= '0;
				end
				else
					cooldown[l] <= cooldown[l] + 1'b1;
			end
		end
	end

	// at most one point per step, whatever the number of lanes hit
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			score <= '0;
		else if (clearGame)
			score <= '0;
		else if (gameStep)
		begin
			if (!playing)
				score <= '0;
			else if (|scoring)
				score <= score + 1'b1;
		end
	end

endmodule

//--- laneSlots.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module laneSlots
(
	input  logic DIV_CLK,
	input  logic reset,
	input  logic gameStep,
	input  logic clearGame,
	input  logic spawnPulse,
	input  rhythmPkg::laneMask_t spawnMask,
	output rhythmPkg::laneMask_t inWindow
);
	import rhythmPkg::*;

	notePos_t slotPos [`LANE_COUNT][`SLOTS_PER_LANE];
	logic [`SLOTS_PER_LANE-1:0] slotActive [`LANE_COUNT];
	// one-hot pick of the slot that takes a new note
	logic [`SLOTS_PER_LANE-1:0] spawnSlot [`LANE_COUNT];

	////////////////////////////////////////
	// free slot search and hit window
	////////////////////////////////////////
	always_comb
	begin
		logic [`SLOTS_PER_LANE-1:0] freeSlots;
		for (int l = 0; l < `LANE_COUNT; l++)
		begin
			freeSlots = ~slotActive[l];
			// lowest set bit of the free mask, zero when the lane is full
			if (spawnPulse && spawnMask[l])
				spawnSlot[l] = freeSlots & (~freeSlots + 1'b1);
			else
				spawnSlot[l] = '0;

			inWindow[l] = 1'b0;
			for (int s = 0; s < `SLOTS_PER_LANE; s++)
			begin
				if (slotActive[l][s] &&
					(slotPos[l][s] >= notePos_t'(`HIT_LOW)) &&
					(slotPos[l][s] <= notePos_t'(`HIT_HIGH)))
					inWindow[l] = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// slot state
	////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			for (int l = 0; l < `LANE_COUNT; l++)
				slotActive[l] <= '0;
		end
		else if (clearGame)
		begin
			for (int l = 0; l < `LANE_COUNT; l++)
				slotActive[l] <= '0;
		end
		else
		begin
			for (int l = 0; l < `LANE_COUNT; l++)
			begin
				for (int s = 0; s < `SLOTS_PER_LANE; s++)
				begin
					// expire one step after passing the limit
					if (gameStep && slotActive[l][s] && (slotPos[l][s] > notePos_t'(`POS_LIMIT)))
						slotActive[l][s] <= 1'b0;
					else if (spawnSlot[l][s])
						slotActive[l][s] <= 1'b1;
				end
			end
		end
	end

	// positions fall by one per step, new notes enter at the top
	always_ff @(posedge DIV_CLK)
	begin
		for (int l = 0; l < `LANE_COUNT; l++)
		begin
			for (int s = 0; s < `SLOTS_PER_LANE; s++)
			begin
				if (spawnSlot[l][s])
					slotPos[l][s] <= '0;
				else if (gameStep && slotActive[l][s])
					slotPos[l][s] <= slotPos[l][s] + 1'b1;
			end
		end
	end

endmodule

//--- noteSequencer.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module noteSequencer
(
	input  logic DIV_CLK,
	input  logic reset,
	input  logic start,
	input  logic restart,
	output logic gameStep,
	output logic playing,
	output logic clearGame,
	output logic spawnPulse,
	output rhythmPkg::laneMask_t spawnMask
);
	import rhythmPkg::*;

	localparam int STEP_BITS  = $clog2(`STEP_DIV);
	localparam int INDEX_BITS = $clog2(`END_COUNT + 1);
	localparam int ROW_BITS   = $clog2(`CHART_LENGTH);

	logic [STEP_BITS-1:0] stepCount;
	logic [`SPAWN_INTERVAL_WIDTH-1:0] intervalCount;
	logic [INDEX_BITS-1:0] chartIndex;
	gameState_t state;
	logic spawnNow;

	////////////////////////////////////////
	// step prescaler
	////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			stepCount <= '0;
			gameStep <= 1'b0;
		end
		else
		begin
			gameStep <= (stepCount == STEP_BITS'(`STEP_DIV - 1));
			if (stepCount == STEP_BITS'(`STEP_DIV - 1))
				stepCount <= '0;
			else
				stepCount <= stepCount + 1'b1;
		end
	end

	// a chart row is read once per interval wrap
	assign spawnNow = gameStep && (state == PLAY) && (intervalCount == '0) &&
		(chartIndex < INDEX_BITS'(`CHART_LENGTH));

	assign playing = (state == PLAY);

	////////////////////////////////////////
	// game FSM
	////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= INITIAL;
			intervalCount <= '0;
			chartIndex <= '0;
			clearGame <= 1'b0;
			spawnPulse <= 1'b0;
		end
		else
		begin
			clearGame <= 1'b0;
			spawnPulse <= spawnNow;
			if (gameStep)
			begin
				case (state)
					INITIAL:
					begin
						intervalCount <= '0;
						chartIndex <= '0;
						if (start)
						begin
							state <= PLAY;
							clearGame <= 1'b1;
						end
					end
					PLAY:
					begin
						intervalCount <= intervalCount + 1'b1;
						if (intervalCount == '0)
						begin
							chartIndex <= chartIndex + 1'b1;
							// rows past the chart are silent, they let notes drain
							if (chartIndex == INDEX_BITS'(`END_COUNT - 1))
								state <= DONE;
						end
					end
					DONE:
					begin
						intervalCount <= '0;
						chartIndex <= '0;
						if (restart)
						begin
							state <= PLAY;
							clearGame <= 1'b1;
						end
					end
					default:
						state <= INITIAL;
				endcase
			end
		end
	end

	always_ff @(posedge DIV_CLK)
	begin
		if (spawnNow)
			spawnMask <= chartRow(chartIndex[ROW_BITS-1:0]);
	end

endmodule

//--- rhythmCfg_cfg.svh
`ifndef RHYTHM_CFG_SVH
`define RHYTHM_CFG_SVH

////////////////////////////////////////
// lane geometry
////////////////////////////////////////
`define LANE_COUNT 3
`define SLOTS_PER_LANE 5
`define POS_WIDTH 10

// a note past this position is dropped on the next step
`define POS_LIMIT 490

// inclusive bounds of the hit window, shared by all lanes
`define HIT_LOW 430
`define HIT_HIGH 470

////////////////////////////////////////
// timing and chart
////////////////////////////////////////
`define SPAWN_INTERVAL_WIDTH 6
`define CHART_LENGTH 32
// extra rows give the last notes time to fall
`define END_COUNT 40
`define STEP_DIV 4
`define COOLDOWN_STEPS 10

////////////////////////////////////////
// score and display
////////////////////////////////////////
`define SCORE_WIDTH 16
`define SCAN_WIDTH 4
`define DIGIT_COUNT 4

`endif

//--- rhythmGame.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module rhythmGame
(
	input  logic DIV_CLK,
	input  logic reset,
	input  logic start,
	input  logic restart,
	input  rhythmPkg::laneMask_t laneButton,
	output logic gameActive,
	output logic [`DIGIT_COUNT-1:0] anode,
	output logic [6:0] cathode
);
	import rhythmPkg::*;

	logic gameStep;
	logic clearGame;
	logic spawnPulse;
	laneMask_t spawnMask;
	laneMask_t inWindow;
	score_t score;

	// chart and game state
	noteSequencer noteSequencer_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.start(start),
		.restart(restart),
		.gameStep(gameStep),
		.playing(gameActive),
		.clearGame(clearGame),
		.spawnPulse(spawnPulse),
		.spawnMask(spawnMask)
	);

	laneSlots laneSlots_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.gameStep(gameStep),
		.clearGame(clearGame),
		.spawnPulse(spawnPulse),
		.spawnMask(spawnMask),
		.inWindow(inWindow)
	);

	hitJudge hitJudge_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.gameStep(gameStep),
		.playing(gameActive),
		.clearGame(clearGame),
		.laneButton(laneButton),
		.inWindow(inWindow),
		.score(score)
	);

	// score in hex on the four digits
	scoreDisplay scoreDisplay_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.score(score),
		.anode(anode),
		.cathode(cathode)
	);

endmodule

//--- rhythmPkg.sv
`include "rhythmCfg_cfg.svh"

package rhythmPkg;

	// one-hot game states
	typedef enum logic [2:0]
	{
		INITIAL = 3'b001,
		PLAY    = 3'b010,
		DONE    = 3'b100
	} gameState_t;

	// bit 2 red, bit 1 green, bit 0 blue
	typedef logic [`LANE_COUNT-1:0] laneMask_t;

	typedef logic [`POS_WIDTH-1:0] notePos_t;

	typedef logic [`SCORE_WIDTH-1:0] score_t;

	// built-in chart, one lane mask per row
	function automatic laneMask_t chartRow(input logic [$clog2(`CHART_LENGTH)-1:0] rowIndex);
		laneMask_t row;
		row = '0;
		case (rowIndex)
			5'd0:  row = 3'b000;
			5'd1:  row = 3'b100;
			5'd2:  row = 3'b010;
			5'd3:  row = 3'b001;
			5'd4:  row = 3'b100;
			5'd5:  row = 3'b010;
			5'd6:  row = 3'b001;
			5'd7:  row = 3'b010;
			5'd8:  row = 3'b100;
			5'd9:  row = 3'b001;
			5'd10: row = 3'b110;
			5'd11: row = 3'b000;
			5'd12: row = 3'b011;
			5'd13: row = 3'b100;
			5'd14: row = 3'b001;
			5'd15: row = 3'b010;
			5'd16: row = 3'b101;
			5'd17: row = 3'b000;
			5'd18: row = 3'b010;
			5'd19: row = 3'b100;
			5'd20: row = 3'b001;
			5'd21: row = 3'b010;
			5'd22: row = 3'b111;
			5'd23: row = 3'b000;
			5'd24: row = 3'b100;
			5'd25: row = 3'b001;
			5'd26: row = 3'b010;
			5'd27: row = 3'b011;
			5'd28: row = 3'b000;
			5'd29: row = 3'b110;
			5'd30: row = 3'b001;
			5'd31: row = 3'b111;
		endcase
		return row;
	endfunction

endpackage

//--- scoreDisplay.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module scoreDisplay
(
	input  logic DIV_CLK,
	input  logic reset,
	input  rhythmPkg::score_t score,
	output logic [`DIGIT_COUNT-1:0] anode,
	output logic [6:0] cathode
);
	localparam int SEL_BITS = $clog2(`DIGIT_COUNT);
	localparam logic [`DIGIT_COUNT-1:0] FIRST_DIGIT = 1;

	logic [`SCAN_WIDTH-1:0] scanCount;
	logic [SEL_BITS-1:0] digitSel;
	logic [3:0] nibble;

	////////////////////////////////////////
	// digit scan
	////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			scanCount <= '0;
		else
			scanCount <= scanCount + 1'b1;
	end

	// top bits pick the digit, digit 0 shows the low nibble
	assign digitSel = scanCount[`SCAN_WIDTH-1 -: SEL_BITS];
	assign anode = ~(FIRST_DIGIT << digitSel);
	assign nibble = score[4*digitSel +: 4];

	////////////////////////////////////////
	// hex to segments, a in bit 6
	////////////////////////////////////////
	always_comb
	begin
		case (nibble)
			4'h0: cathode = 7'b0000001;
			4'h1: cathode = 7'b1001111;
			4'h2: cathode = 7'b0010010;
			4'h3: cathode = 7'b0000110;
			4'h4: cathode = 7'b1001100;
			4'h5: cathode = 7'b0100100;
			4'h6: cathode = 7'b0100000;
			4'h7: cathode = 7'b0001111;
			4'h8: cathode = 7'b0000000;
			4'h9: cathode = 7'b0000100;
			4'hA: cathode = 7'b0001000;
			4'hB: cathode = 7'b1100000;
			4'hC: cathode = 7'b0110001;
			4'hD: cathode = 7'b1000010;
			4'hE: cathode = 7'b0110000;
			// F
			default: cathode = 7'b0111000;
		endcase
	end

endmodule

//--- tb_rhythmChecks.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module tb_rhythmChecks
(
	input  logic DIV_CLK,
	input  logic reset,
	input  logic gameActive,
	input  logic [`DIGIT_COUNT-1:0] anode,
	input  logic [6:0] cathode,
	input  logic expectZero,
	output int valueErrors,
	output int otherErrors
);
	// a digit stays lit while the low scan bits count through
	localparam int HOLD_CYCLES = 1 << (`SCAN_WIDTH - 2);
	localparam int STEPS_PER_SCAN = `DIGIT_COUNT * HOLD_CYCLES / `STEP_DIV;
	localparam logic [`DIGIT_COUNT-1:0] ONE_DIGIT = 1;

	int valueCount = 0;
	int otherCount = 0;
	int digit;
	int prevDigit = 0;
	int holdCount = 0;
	int limit;
	logic wasReset = 1'b0;
	logic wasActive = 1'b0;
	logic scoreShown = 1'b0;
	logic [4:0] decoded;
	logic [3:0] delta;
	logic [3:0] lastNibble [`DIGIT_COUNT];
	logic [`DIGIT_COUNT-1:0] nibbleSeen = '0;

	assign valueErrors = valueCount;
	assign otherErrors = otherCount;

	////////////////////////////////////////
	// segment model
	////////////////////////////////////////
	// active low, a in bit 6 down to g in bit 0; bit 4 of the result marks a hex digit
	function automatic logic [4:0] segmentsToHex(input logic [6:0] seg);
		logic [4:0] hex;
		case (seg)
			7'b0000001: hex = 5'h10;
			7'b1001111: hex = 5'h11;
			7'b0010010: hex = 5'h12;
			7'b0000110: hex = 5'h13;
			7'b1001100: hex = 5'h14;
			7'b0100100: hex = 5'h15;
			7'b0100000: hex = 5'h16;
			7'b0001111: hex = 5'h17;
			7'b0000000: hex = 5'h18;
			7'b0000100: hex = 5'h19;
			7'b0001000: hex = 5'h1A;
			7'b1100000: hex = 5'h1B;
			7'b0110001: hex = 5'h1C;
			7'b1000010: hex = 5'h1D;
			7'b0110000: hex = 5'h1E;
			7'b0111000: hex = 5'h1F;
			default: hex = 5'h00;
		endcase
		return hex;
	endfunction

	// index of the one low anode bit, -1 if none or several are low
	function automatic int litDigit(input logic [`DIGIT_COUNT-1:0] an);
		int idx;
		idx = -1;
		if ($countones(~an) == 1)
		begin
			for (int i = 0; i < `DIGIT_COUNT; i++)
			begin
				if (!an[i])
					idx = i;
			end
		end
		return idx;
	endfunction

	task automatic reportValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		valueCount++;
		$display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
	endtask

	task automatic reportOther(input string what);
		otherCount++;
		$display("error at %0t: %s", $time, what);
	endtask

	////////////////////////////////////////
	// checks, sampled on the falling edge
	////////////////////////////////////////
	always @(negedge DIV_CLK)
	begin
		decoded = segmentsToHex(cathode);
		digit = litDigit(anode);

		assert (digit >= 0)
		else
			reportOther($sformatf("anode 0x%h does not select exactly one digit", anode));
		assert (decoded[4])
		else
			reportOther($sformatf("cathode 0x%h is not a hex digit pattern", cathode));

		if (reset)
		begin
			// reset stops the game and shows 0000 right away
			assert (gameActive == 1'b0)
			else
				reportValue("gameActive", 32'(gameActive), 32'h0);
			assert (anode == 4'b1110)
			else
				reportValue("anode", 32'(anode), 32'he);
			assert (decoded == 5'h10)
			else
				reportValue("cathode", 32'(cathode), 32'h01);
			prevDigit = 0;
			holdCount = 0;
			nibbleSeen = '0;
		end
		else if (digit >= 0)
		begin
			if (wasReset)
			begin
				assert (gameActive == 1'b0)
				else
					reportValue("gameActive", 32'(gameActive), 32'h0);
				assert (anode == 4'b1110)
				else
					reportValue("anode", 32'(anode), 32'he);
			end

			// digits rotate 0 to 3, each lit for the same number of cycles
			if (digit == prevDigit)
				holdCount++;
			else
			begin
				assert (holdCount == HOLD_CYCLES)
				else
					reportOther($sformatf("digit %0d stayed lit for %0d cycles", prevDigit,
						holdCount));
				assert (digit == (prevDigit + 1) % `DIGIT_COUNT)
				else
					reportValue("anode", 32'(anode),
						32'(~(ONE_DIGIT << ((prevDigit + 1) % `DIGIT_COUNT))));
				holdCount = 1;
			end
			prevDigit = digit;

			if (expectZero)
			begin
				assert (decoded == 5'h10)
				else
					reportValue($sformatf("score digit %0d", digit), 32'(decoded[3:0]), 32'h0);
			end

			// one sample per digit and scan, taken on its last lit cycle
			if (!gameActive)
				nibbleSeen = '0;
			else if (holdCount == HOLD_CYCLES && decoded[4])
			begin
				if (nibbleSeen[digit])
				begin
					delta = decoded[3:0] - lastNibble[digit];
					limit = (digit == 0) ? STEPS_PER_SCAN : 1;
					assert (int'(delta) <= limit)
					else
						reportOther($sformatf("score digit %0d went from 0x%h to 0x%h in one scan",
							digit, lastNibble[digit], decoded[3:0]));
				end
				lastNibble[digit] = decoded[3:0];
				nibbleSeen[digit] = 1'b1;
			end
		end

		// a game must show a nonzero score before it ends
		if (wasActive && !gameActive)
		begin
			assert (scoreShown)
			else
				reportOther("a game ended without the score ever leaving zero");
			scoreShown = 1'b0;
		end
		else if (gameActive && decoded[4] && decoded[3:0] != 4'h0)
			scoreShown = 1'b1;
		wasActive = gameActive;
		wasReset = reset;
	end

endmodule

//--- tb_rhythmGame.sv
`timescale 1ns/1ps
`include "rhythmCfg_cfg.svh"

module tb_rhythmGame;

	localparam int CLK_PERIOD = 100;
	localparam int SCAN_CYCLES = 1 << `SCAN_WIDTH;
	localparam int GAME_STEPS = `END_COUNT << `SPAWN_INTERVAL_WIDTH;

	logic DIV_CLK = 1'b0;
	logic reset = 1'b1;
	logic start = 1'b0;
	logic restart = 1'b0;
	logic [`LANE_COUNT-1:0] laneButton = '0;
	logic expectZero = 1'b1;
	logic gameActive;
	logic [`DIGIT_COUNT-1:0] anode;
	logic [6:0] cathode;
	logic [31:0] randState = 32'd83;
	int valueErrors;
	int otherErrors;
	int timeoutCount = 0;

	always #(CLK_PERIOD / 2) DIV_CLK = ~DIV_CLK;

	rhythmGame rhythmGame_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.start(start),
		.restart(restart),
		.laneButton(laneButton),
		.gameActive(gameActive),
		.anode(anode),
		.cathode(cathode)
	);

	tb_rhythmChecks checks_inst
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.gameActive(gameActive),
		.anode(anode),
		.cathode(cathode),
		.expectZero(expectZero),
		.valueErrors(valueErrors),
		.otherErrors(otherErrors)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic idleCycles(input int count);
		repeat (count) @(posedge DIV_CLK);
	endtask

	task automatic waitForActive(input int limit, input string what);
		int n;
		n = 0;
		@(negedge DIV_CLK);
		while (gameActive !== 1'b1 && n < limit)
		begin
			@(negedge DIV_CLK);
			n++;
		end
		if (gameActive !== 1'b1)
		begin
			timeoutCount++;
			$display("timeout: %s did not raise gameActive within %0d cycles", what, limit);
		end
	endtask

	// new pattern every step, each lane pressed about one step in eight
	task automatic pressRandom(input int limit, input logic untilIdle);
		int n;
		logic idle;
		n = 0;
		idle = 1'b0;
		while (n < limit && !(untilIdle && idle))
		begin
			@(posedge DIV_CLK);
			if (n % `STEP_DIV == 0)
			begin
				randState = lcgNext(randState);
				laneButton <= randState[30:28] & randState[27:25] & randState[24:22];
			end
			@(negedge DIV_CLK);
			idle = !gameActive;
			n++;
		end
		@(posedge DIV_CLK);
		laneButton <= '0;
		if (untilIdle && !idle)
		begin
			timeoutCount++;
			$display("timeout: the game did not end within %0d cycles", limit);
		end
	endtask

	initial
	begin
		idleCycles(5);
		reset <= 1'b0;
		// INITIAL shows 0000
		idleCycles(2 * SCAN_CYCLES);
		start <= 1'b1;
		waitForActive(2 * `STEP_DIV, "start");
		@(posedge DIV_CLK);
		start <= 1'b0;

		////////////////////////////////////////
		// first game
		////////////////////////////////////////
		// no note can reach the hit window yet
		pressRandom(400 * `STEP_DIV, 1'b0);
		expectZero <= 1'b0;
		pressRandom((GAME_STEPS + 64) * `STEP_DIV, 1'b1);
		// DONE clears the score on its first step
		idleCycles(2 * `STEP_DIV);
		expectZero <= 1'b1;
		idleCycles(2 * SCAN_CYCLES);

		////////////////////////////////////////
		// restart, then reset mid-game
		////////////////////////////////////////
		restart <= 1'b1;
		waitForActive(2 * `STEP_DIV, "restart");
		@(posedge DIV_CLK);
		restart <= 1'b0;
		pressRandom(100 * `STEP_DIV, 1'b0);
		expectZero <= 1'b0;
		pressRandom(600 * `STEP_DIV, 1'b0);
		reset <= 1'b1;
		// the whole display reads 0000 from the reset on
		expectZero <= 1'b1;
		idleCycles(5);
		reset <= 1'b0;
		idleCycles(2 * SCAN_CYCLES);

		$display("errors: %0d wrong values, %0d other failures, %0d timeouts",
			valueErrors, otherErrors, timeoutCount);
		if (valueErrors == 0 && otherErrors == 0 && timeoutCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
